// File: ex_ft_pkg.sv
/*
 * Shared definitions for the fault-tolerant execute stage
 * Datapath widths and redundant lane count
 * ALU operation encoding
 * Lane request, decode control and register-file write port structs
 */
package ex_ft_pkg;

  // Datapath and register address widths
  localparam int unsigned DATA_W  = 32;
  localparam int unsigned ADDR_W  = 6;
  // Number of redundant ALU copies
  localparam int unsigned N_LANES = 3;

  // Comparison operations sit at the top of the encoding, from ALU_SLT up
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SLT  = 4'd7,
    ALU_SLTU = 4'd8,
    ALU_EQ   = 4'd9,
    ALU_NE   = 4'd10,
    ALU_LT   = 4'd11,
    ALU_GE   = 4'd12
  } alu_op_e;

  // One lane's copy of the ALU request
  typedef struct packed {
    logic              en;
    alu_op_e           op;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
    // Jump target, carried along
    logic [DATA_W-1:0] operand_c;
  } alu_req_t;

  // Control from decode, already voted there
  typedef struct packed {
    logic              alu_we;
    logic [ADDR_W-1:0] alu_waddr;
    logic              csr_access;
    logic              lsu_en;
    logic              branch;
    logic              regfile_we;
    logic [ADDR_W-1:0] regfile_waddr;
  } ex_ctrl_t;

  // Register-file write port
  typedef struct packed {
    logic              we;
    logic [ADDR_W-1:0] waddr;
    logic [DATA_W-1:0] wdata;
  } wb_port_t;

  // One flag per lane
  typedef logic [N_LANES-1:0] lane_vec_t;

endpackage

// File: ex_alu.sv
/*
 * Single integer ALU lane
 * Add, subtract, logic and shift operations
 * Signed and unsigned comparisons for set-less-than and branches
 */
`timescale 1ns/100ps

module ex_alu (
  input  ex_ft_pkg::alu_req_t          req_i,
  output logic [ex_ft_pkg::DATA_W-1:0] result_o,
  output logic                         cmp_o
);

  localparam int unsigned SHAMT_W = $clog2(ex_ft_pkg::DATA_W);

  logic [ex_ft_pkg::DATA_W-1:0] op_a;
  logic [ex_ft_pkg::DATA_W-1:0] op_b;
  logic [SHAMT_W-1:0]           shamt;
  logic                         lt_signed;
  logic                         lt_unsigned;

  assign op_a  = req_i.operand_a;
  assign op_b  = req_i.operand_b;
  // Shift amount from the low bits of operand b
  assign shamt = op_b[SHAMT_W-1:0];

  // Shared comparators for SLT, SLTU and the branch compares
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  // Comparison bit, zero for non-compare operations
  always_comb begin
    case (req_i.op)
      ex_ft_pkg::ALU_SLT,
      ex_ft_pkg::ALU_LT:   cmp_o = lt_signed;
      ex_ft_pkg::ALU_SLTU: cmp_o = lt_unsigned;
      ex_ft_pkg::ALU_EQ:   cmp_o = (op_a == op_b);
      ex_ft_pkg::ALU_NE:   cmp_o = (op_a != op_b);
      ex_ft_pkg::ALU_GE:   cmp_o = ~lt_signed;
      default:             cmp_o = 1'b0;
    endcase
  end

  // Result word
  always_comb begin
    case (req_i.op)
      ex_ft_pkg::ALU_ADD: result_o = op_a + op_b;
      ex_ft_pkg::ALU_SUB: result_o = op_a - op_b;
      ex_ft_pkg::ALU_AND: result_o = op_a & op_b;
      ex_ft_pkg::ALU_OR:  result_o = op_a | op_b;
      ex_ft_pkg::ALU_XOR: result_o = op_a ^ op_b;
      ex_ft_pkg::ALU_SLL: result_o = op_a << shamt;
      ex_ft_pkg::ALU_SRL: result_o = op_a >> shamt;
      // Compares return their truth value zero-extended
      default:            result_o = {{(ex_ft_pkg::DATA_W-1){1'b0}}, cmp_o};
    endcase
  end

  // Decode never issues an unused encoding to an enabled lane
  a_legal_op: assert final (req_i.en !== 1'b1 || req_i.op <= ex_ft_pkg::ALU_GE)
    else $error("ex_alu illegal operation %0h on enabled lane", req_i.op);

endmodule

// File: ex_tmr_voter.sv
/*
 * Bitwise majority voter over three ALU lanes
 * Corrected and detected error flags
 * Saturating mismatch counters with sticky permanent-fault flags
 */
`timescale 1ns/100ps

module ex_tmr_voter #(
  parameter int unsigned FAULT_LIMIT = 4
) (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic                                                 en_i,
  input  logic [ex_ft_pkg::N_LANES-1:0][ex_ft_pkg::DATA_W-1:0] result_i,
  input  ex_ft_pkg::lane_vec_t                                 cmp_i,
  output logic [ex_ft_pkg::DATA_W-1:0]                         result_o,
  output logic                                                 cmp_o,
  output logic                                                 err_corrected_o,
  output logic                                                 err_detected_o,
  output ex_ft_pkg::lane_vec_t                                 faulty_lane_o
);

  // Counter value that reaches FAULT_LIMIT on the next mismatch
  localparam logic [3:0] SET_AT = 4'(FAULT_LIMIT - 1);

  ex_ft_pkg::lane_vec_t                   mismatch;
  logic [ex_ft_pkg::N_LANES-1:0][3:0]     fault_cnt_q;

  //////////////////////////////
  // Majority vote
  //////////////////////////////
  assign result_o = (result_i[0] & result_i[1]) |
                    (result_i[0] & result_i[2]) |
                    (result_i[1] & result_i[2]);
  assign cmp_o    = (cmp_i[0] & cmp_i[1]) | (cmp_i[0] & cmp_i[2]) | (cmp_i[1] & cmp_i[2]);

  // A lane disagrees if either its word or its compare bit is off
  always_comb begin
    for (int i = 0; i < ex_ft_pkg::N_LANES; i++) begin
      mismatch[i] = (result_i[i] != result_o) || (cmp_i[i] != cmp_o);
    end
  end

  assign err_detected_o  = |mismatch;
  // Single outlier is masked by the vote
  assign err_corrected_o = ($countones(mismatch) == 1);

  //////////////////////////////
  // Permanent-fault tracking
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_cnt_q   <= '0;
      faulty_lane_o <= '0;
    end else if (en_i) begin
      for (int i = 0; i < ex_ft_pkg::N_LANES; i++) begin
        // Saturate at 15
        if (mismatch[i] && fault_cnt_q[i] != 4'hF) begin
          fault_cnt_q[i] <= fault_cnt_q[i] + 4'd1;
        end
        if (mismatch[i] && fault_cnt_q[i] >= SET_AT) begin
          faulty_lane_o[i] <= 1'b1;
        end
      end
    end
  end

  a_corr_is_det: assert property (@(posedge clk) disable iff (!rst_n)
    err_corrected_o |-> err_detected_o);

endmodule

// File: ex_tmr_alu.sv
/*
 * Redundant ALU block
 * Three ALU lanes, enable vote and result voter
 */
`timescale 1ns/100ps

module ex_tmr_alu #(
  parameter int unsigned FAULT_LIMIT = 4
) (
  input  logic                                          clk,
  input  logic                                          rst_n,
  input  ex_ft_pkg::alu_req_t [ex_ft_pkg::N_LANES-1:0]  req_i,
  output logic                                          alu_en_o,
  output logic [ex_ft_pkg::DATA_W-1:0]                  result_o,
  output logic                                          cmp_o,
  output logic                                          err_corrected_o,
  output logic                                          err_detected_o,
  output ex_ft_pkg::lane_vec_t                          faulty_lane_o
);

  logic [ex_ft_pkg::N_LANES-1:0][ex_ft_pkg::DATA_W-1:0] lane_result;
  ex_ft_pkg::lane_vec_t                                 lane_cmp;
  ex_ft_pkg::lane_vec_t                                 lane_en;

  //////////////////////////////
  // ALU lanes
  //////////////////////////////
  for (genvar i = 0; i < ex_ft_pkg::N_LANES; i++) begin : g_lane
    ex_alu i_alu (
      .req_i    (req_i[i]),
      .result_o (lane_result[i]),
      .cmp_o    (lane_cmp[i])
    );
    assign lane_en[i] = req_i[i].en;
  end

  // Enable is voted too, so a flipped enable in one lane cannot fire the ALU
  assign alu_en_o = (lane_en[0] & lane_en[1]) | (lane_en[0] & lane_en[2]) |
                    (lane_en[1] & lane_en[2]);

  //////////////////////////////
  // Voter
  //////////////////////////////
  ex_tmr_voter #(
    .FAULT_LIMIT (FAULT_LIMIT)
  ) i_voter (
    .clk             (clk),
    .rst_n           (rst_n),
    .en_i            (alu_en_o),
    .result_i        (lane_result),
    .cmp_i           (lane_cmp),
    .result_o        (result_o),
    .cmp_o           (cmp_o),
    .err_corrected_o (err_corrected_o),
    .err_detected_o  (err_detected_o),
    .faulty_lane_o   (faulty_lane_o)
  );

endmodule

// File: ex_wb_reg.sv
/*
 * EX/WB pipeline register for the LSU write port
 * Captures load write-back enable and address, holds under back-pressure
 */
`timescale 1ns/100ps

module ex_wb_reg (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         ex_valid_i,
  input  logic                         wb_ready_i,
  input  logic                         lsu_err_i,
  input  logic                         regfile_we_i,
  input  logic [ex_ft_pkg::ADDR_W-1:0] regfile_waddr_i,
  output ex_ft_pkg::wb_port_t          lsu_port_o
);

  logic                         we_q;
  logic [ex_ft_pkg::ADDR_W-1:0] waddr_q;
  logic                         load_we;

  // A faulting load never writes the register file
  assign load_we = regfile_we_i & ~lsu_err_i;

  // Write enable
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      we_q <= 1'b0;
    end else if (ex_valid_i) begin
      // wb_ready_i is already folded into ex_valid_i
      we_q <= load_we;
    end else if (wb_ready_i) begin
      // WB drained and nothing new, so flush the slot
      we_q <= 1'b0;
    end
  end

  // Address is only taken for a real write-back
  always_ff @(posedge clk) begin
    if (ex_valid_i && load_we) begin
      waddr_q <= regfile_waddr_i;
    end
  end

  assign lsu_port_o.we    = we_q;
  assign lsu_port_o.waddr = waddr_q;
  // Load data joins at the write-port driver
  assign lsu_port_o.wdata = '0;

  // we only comes from a valid EX cycle or from holding under a stalled WB
  a_we_origin: assert property (@(posedge clk) disable iff (!rst_n)
    we_q |-> $past(ex_valid_i || (we_q && !wb_ready_i)));

endmodule

// File: ex_fw_mux.sv
/*
 * ALU write-port mux for the forwarding path
 * LSU write-port driver that attaches the load data
 */
`timescale 1ns/100ps

module ex_fw_mux (
  input  ex_ft_pkg::ex_ctrl_t          ctrl_i,
  input  logic                         alu_en_i,
  input  logic [ex_ft_pkg::DATA_W-1:0] alu_result_i,
  input  logic [ex_ft_pkg::DATA_W-1:0] csr_rdata_i,
  input  logic [ex_ft_pkg::DATA_W-1:0] lsu_rdata_i,
  input  ex_ft_pkg::wb_port_t          lsu_port_i,
  output ex_ft_pkg::wb_port_t          fw_port_o,
  output ex_ft_pkg::wb_port_t          wb_port_o
);

  //////////////////////////////
  // ALU write port
  //////////////////////////////
  always_comb begin
    fw_port_o.we    = ctrl_i.alu_we;
    fw_port_o.waddr = ctrl_i.alu_waddr;
    // CSR read data wins over the ALU
    if (ctrl_i.csr_access) begin
      fw_port_o.wdata = csr_rdata_i;
    end else if (alu_en_i) begin
      fw_port_o.wdata = alu_result_i;
    end else begin
      fw_port_o.wdata = '0;
    end
  end

  //////////////////////////////
  // LSU write port
  //////////////////////////////
  // Enable and address come registered, data arrives this cycle
  always_comb begin
    wb_port_o       = lsu_port_i;
    wb_port_o.wdata = lsu_rdata_i;
  end

  // Decode never issues an ALU op and a CSR access together
  a_one_source: assert final (!(alu_en_i === 1'b1 && ctrl_i.csr_access === 1'b1))
    else $error("ex_fw_mux ALU enable and CSR access both set");

endmodule

// File: ex_stage_ft.sv
/*
 * Fault-tolerant execute stage top level
 * Redundant ALU, EX/WB register and write-port mux
 * Stall handshake, branch decision and jump target
 */
`timescale 1ns/100ps

module ex_stage_ft #(
  parameter int unsigned FAULT_LIMIT = 4
) (
  input  logic                                         clk,
  input  logic                                         rst_n,
  input  ex_ft_pkg::alu_req_t [ex_ft_pkg::N_LANES-1:0] alu_req_i,
  input  ex_ft_pkg::ex_ctrl_t                          ctrl_i,
  input  logic [ex_ft_pkg::DATA_W-1:0]                 csr_rdata_i,
  input  logic [ex_ft_pkg::DATA_W-1:0]                 lsu_rdata_i,
  input  logic                                         lsu_ready_i,
  input  logic                                         lsu_err_i,
  input  logic                                         wb_ready_i,
  output ex_ft_pkg::wb_port_t                          fw_port_o,
  output ex_ft_pkg::wb_port_t                          wb_port_o,
  output logic                                         branch_decision_o,
  output logic [ex_ft_pkg::DATA_W-1:0]                 jump_target_o,
  output logic                                         ex_ready_o,
  output logic                                         ex_valid_o,
  output logic                                         err_corrected_o,
  output logic                                         err_detected_o,
  output ex_ft_pkg::lane_vec_t                         faulty_lane_o
);

  logic                         alu_en;
  logic [ex_ft_pkg::DATA_W-1:0] alu_result;
  logic                         alu_cmp;
  ex_ft_pkg::wb_port_t          lsu_port;

  ex_tmr_alu #(
    .FAULT_LIMIT (FAULT_LIMIT)
  ) i_tmr_alu (
    .clk             (clk),
    .rst_n           (rst_n),
    .req_i           (alu_req_i),
    .alu_en_o        (alu_en),
    .result_o        (alu_result),
    .cmp_o           (alu_cmp),
    .err_corrected_o (err_corrected_o),
    .err_detected_o  (err_detected_o),
    .faulty_lane_o   (faulty_lane_o)
  );

  ex_wb_reg i_wb_reg (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_valid_i      (ex_valid_o),
    .wb_ready_i      (wb_ready_i),
    .lsu_err_i       (lsu_err_i),
    .regfile_we_i    (ctrl_i.regfile_we),
    .regfile_waddr_i (ctrl_i.regfile_waddr),
    .lsu_port_o      (lsu_port)
  );

  ex_fw_mux i_fw_mux (
    .ctrl_i       (ctrl_i),
    .alu_en_i     (alu_en),
    .alu_result_i (alu_result),
    .csr_rdata_i  (csr_rdata_i),
    .lsu_rdata_i  (lsu_rdata_i),
    .lsu_port_i   (lsu_port),
    .fw_port_o    (fw_port_o),
    .wb_port_o    (wb_port_o)
  );

  // Branches resolve here, so the target comes straight from lane 0
  assign branch_decision_o = alu_cmp;
  assign jump_target_o     = alu_req_i[0].operand_c;

  // Valid flows forward and ready backward, a branch completes without WB
  assign ex_ready_o = (lsu_ready_i & wb_ready_i) | ctrl_i.branch;
  assign ex_valid_o = (ctrl_i.csr_access | ctrl_i.lsu_en | alu_en) & lsu_ready_i & wb_ready_i;

  // Accepted load shows up on the LSU port one cycle later
  a_load_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o && ctrl_i.regfile_we && !lsu_err_i |=>
      wb_port_o.we && wb_port_o.waddr == $past(ctrl_i.regfile_waddr));

endmodule

// File: tb_ex_stage_ft.sv
/*
 * Testbench for the fault-tolerant execute stage
 * Reference ALU, expected fault counters and EX/WB register model
 * Concurrent checks on every DUT output, six directed tests, timeout
 */
`timescale 1ns/100ps

module tb_ex_stage_ft;

  localparam int unsigned FAULT_LIMIT    = 4;
  // Reset and all test cycles rounded up
  localparam int unsigned STIM_CYCLES    = 140;
  localparam int unsigned TIMEOUT_CYCLES = 10 * STIM_CYCLES;

  logic clk;
  logic rst_n;
  ex_ft_pkg::alu_req_t [ex_ft_pkg::N_LANES-1:0] alu_req;
  ex_ft_pkg::alu_req_t          clean_req;
  ex_ft_pkg::ex_ctrl_t          ctrl;
  logic [ex_ft_pkg::DATA_W-1:0] csr_rdata;
  logic [ex_ft_pkg::DATA_W-1:0] lsu_rdata;
  logic                         lsu_ready;
  logic                         lsu_err;
  logic                         wb_ready;
  ex_ft_pkg::wb_port_t          fw_port;
  ex_ft_pkg::wb_port_t          wb_port;
  logic                         branch_decision;
  logic [ex_ft_pkg::DATA_W-1:0] jump_target;
  logic                         ex_ready;
  logic                         ex_valid;
  logic                         err_corrected;
  logic                         err_detected;
  ex_ft_pkg::lane_vec_t         faulty_lane;

  // Expected values
  logic [ex_ft_pkg::DATA_W:0]         ref_word;
  logic [ex_ft_pkg::DATA_W-1:0]       exp_fw_wdata;
  logic                               exp_en;
  logic                               exp_valid;
  logic                               exp_ready;
  ex_ft_pkg::lane_vec_t               exp_mis;
  ex_ft_pkg::lane_vec_t               exp_faulty;
  logic [ex_ft_pkg::N_LANES-1:0][3:0] exp_cnt;
  logic                               exp_we;
  logic [ex_ft_pkg::ADDR_W-1:0]       exp_waddr;

  int seed = 57827;
  int err_cnt;
  int pass_cnt;
  int fail_cnt;
  int errs_before;
  int cycle_cnt;
  logic [ex_ft_pkg::DATA_W-1:0] opa;
  logic [ex_ft_pkg::DATA_W-1:0] mask;

  ex_stage_ft #(.FAULT_LIMIT(FAULT_LIMIT)) i_dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_req_i         (alu_req),
    .ctrl_i            (ctrl),
    .csr_rdata_i       (csr_rdata),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_i       (lsu_ready),
    .lsu_err_i         (lsu_err),
    .wb_ready_i        (wb_ready),
    .fw_port_o         (fw_port),
    .wb_port_o         (wb_port),
    .branch_decision_o (branch_decision),
    .jump_target_o     (jump_target),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .err_corrected_o   (err_corrected),
    .err_detected_o    (err_detected),
    .faulty_lane_o     (faulty_lane)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////
  // Returns {compare bit, result word}
  function automatic logic [ex_ft_pkg::DATA_W:0] alu_ref(ex_ft_pkg::alu_op_e op,
      logic [ex_ft_pkg::DATA_W-1:0] a, logic [ex_ft_pkg::DATA_W-1:0] b);
    logic                         cmp;
    logic [ex_ft_pkg::DATA_W-1:0] res;
    cmp = 1'b0;
    res = '0;
    case (op)
      ex_ft_pkg::ALU_ADD:  res = a + b;
      ex_ft_pkg::ALU_SUB:  res = a - b;
      ex_ft_pkg::ALU_AND:  res = a & b;
      ex_ft_pkg::ALU_OR:   res = a | b;
      ex_ft_pkg::ALU_XOR:  res = a ^ b;
      ex_ft_pkg::ALU_SLL:  res = a << b[4:0];
      ex_ft_pkg::ALU_SRL:  res = a >> b[4:0];
      ex_ft_pkg::ALU_SLTU: cmp = a < b;
      ex_ft_pkg::ALU_EQ:   cmp = a == b;
      ex_ft_pkg::ALU_NE:   cmp = a != b;
      ex_ft_pkg::ALU_GE:   cmp = $signed(a) >= $signed(b);
      default:             cmp = $signed(a) < $signed(b);
    endcase
    // Compares give a zero-extended truth value
    if (op >= ex_ft_pkg::ALU_SLT) res = {{(ex_ft_pkg::DATA_W-1){1'b0}}, cmp};
    return {cmp, res};
  endfunction

  always_comb begin
    ref_word  = alu_ref(clean_req.op, clean_req.operand_a, clean_req.operand_b);
    exp_en    = (alu_req[0].en & alu_req[1].en) | (alu_req[0].en & alu_req[2].en) |
                (alu_req[1].en & alu_req[2].en);
    exp_valid = (ctrl.csr_access | ctrl.lsu_en | exp_en) & lsu_ready & wb_ready;
    exp_ready = (lsu_ready & wb_ready) | ctrl.branch;
    if (ctrl.csr_access) exp_fw_wdata = csr_rdata;
    else if (exp_en) exp_fw_wdata = ref_word[ex_ft_pkg::DATA_W-1:0];
    else exp_fw_wdata = '0;
  end

  // Fault counters and EX/WB register as the stage should hold them
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_cnt    <= '0;
      exp_faulty <= '0;
      exp_we     <= 1'b0;
    end else begin
      for (int i = 0; i < ex_ft_pkg::N_LANES; i++) begin
        if (exp_en && exp_mis[i]) begin
          if (exp_cnt[i] != 4'hF) exp_cnt[i] <= exp_cnt[i] + 4'd1;
          if (int'(exp_cnt[i]) + 1 >= FAULT_LIMIT) exp_faulty[i] <= 1'b1;
        end
      end
      if (exp_valid) begin
        exp_we <= ctrl.regfile_we & ~lsu_err;
        if (ctrl.regfile_we && !lsu_err) exp_waddr <= ctrl.regfile_waddr;
      end else if (wb_ready) begin
        exp_we <= 1'b0;
      end
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////
  task automatic flag_mismatch(string name, logic [31:0] got, logic [31:0] exp);
    err_cnt++;
    $display("Error: %s got %h expected %h at %0t", name, got, exp, $time);
  endtask

  a_fw_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    fw_port.wdata == exp_fw_wdata)
    else flag_mismatch("fw_port_o.wdata", $sampled(fw_port.wdata), $sampled(exp_fw_wdata));
  a_fw_we: assert property (@(posedge clk) disable iff (!rst_n) fw_port.we == ctrl.alu_we)
    else flag_mismatch("fw_port_o.we", $sampled(fw_port.we), $sampled(ctrl.alu_we));
  a_fw_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    fw_port.waddr == ctrl.alu_waddr)
    else flag_mismatch("fw_port_o.waddr", $sampled(fw_port.waddr), $sampled(ctrl.alu_waddr));
  a_branch: assert property (@(posedge clk) disable iff (!rst_n)
    branch_decision == ref_word[ex_ft_pkg::DATA_W])
    else flag_mismatch("branch_decision_o", $sampled(branch_decision),
      $sampled(ref_word[ex_ft_pkg::DATA_W]));
  a_jump: assert property (@(posedge clk) disable iff (!rst_n)
    jump_target == clean_req.operand_c)
    else flag_mismatch("jump_target_o", $sampled(jump_target), $sampled(clean_req.operand_c));
  a_det: assert property (@(posedge clk) disable iff (!rst_n) err_detected == |exp_mis)
    else flag_mismatch("err_detected_o", $sampled(err_detected), $sampled(|exp_mis));
  a_corr: assert property (@(posedge clk) disable iff (!rst_n)
    err_corrected == ($countones(exp_mis) == 1))
    else flag_mismatch("err_corrected_o", $sampled(err_corrected),
      $sampled($countones(exp_mis) == 1));
  a_faulty: assert property (@(posedge clk) disable iff (!rst_n) faulty_lane == exp_faulty)
    else flag_mismatch("faulty_lane_o", $sampled(faulty_lane), $sampled(exp_faulty));
  a_valid: assert property (@(posedge clk) disable iff (!rst_n) ex_valid == exp_valid)
    else flag_mismatch("ex_valid_o", $sampled(ex_valid), $sampled(exp_valid));
  a_ready: assert property (@(posedge clk) disable iff (!rst_n) ex_ready == exp_ready)
    else flag_mismatch("ex_ready_o", $sampled(ex_ready), $sampled(exp_ready));
  a_wb_we: assert property (@(posedge clk) disable iff (!rst_n) wb_port.we == exp_we)
    else flag_mismatch("wb_port_o.we", $sampled(wb_port.we), $sampled(exp_we));
  a_wb_waddr: assert property (@(posedge clk) disable iff (!rst_n)
    exp_we |-> wb_port.waddr == exp_waddr)
    else flag_mismatch("wb_port_o.waddr", $sampled(wb_port.waddr), $sampled(exp_waddr));
  a_wb_wdata: assert property (@(posedge clk) disable iff (!rst_n) wb_port.wdata == lsu_rdata)
    else flag_mismatch("wb_port_o.wdata", $sampled(wb_port.wdata), $sampled(lsu_rdata));

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // All three lanes get the same request
  task automatic drive_lanes(ex_ft_pkg::alu_op_e op, logic [31:0] a, logic [31:0] b,
      logic [31:0] c, logic en);
    clean_req.en        = en;
    clean_req.op        = op;
    clean_req.operand_a = a;
    clean_req.operand_b = b;
    clean_req.operand_c = c;
    for (int i = 0; i < ex_ft_pkg::N_LANES; i++) alu_req[i] = clean_req;
    exp_mis = '0;
  endtask

  task automatic close_test(string name);
    if (err_cnt == errs_before) begin
      pass_cnt++;
      $display("%s: passed", name);
    end else begin
      fail_cnt++;
      $display("%s: failed with %0d errors", name, err_cnt - errs_before);
    end
    errs_before = err_cnt;
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////
  initial begin
    rst_n = 1'b0;
    ctrl = '0;
    csr_rdata = '0;
    lsu_rdata = '0;
    lsu_ready = 1'b1;
    lsu_err = 1'b0;
    wb_ready = 1'b1;
    drive_lanes(ex_ft_pkg::ALU_ADD, '0, '0, '0, 1'b0);
    err_cnt = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    errs_before = 0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;

    // 1. Every operation on identical lanes
    ctrl.alu_we = 1'b1;
    ctrl.alu_waddr = 6'd5;
    for (int k = 0; k <= 12; k++) begin
      for (int n = 0; n < 4; n++) begin
        drive_lanes(ex_ft_pkg::alu_op_e'(k), $random(seed), $random(seed), $random(seed), 1'b1);
        next_cycle();
      end
    end
    close_test("ALU forwarding");

    // 2. Compares with equal operands in half of the cycles
    ctrl.branch = 1'b1;
    for (int k = 7; k <= 12; k++) begin
      for (int n = 0; n < 4; n++) begin
        opa = $random(seed);
        drive_lanes(ex_ft_pkg::alu_op_e'(k), opa, n[0] ? $random(seed) : opa, $random(seed),
          1'b1);
        next_cycle();
      end
    end
    ctrl.branch = 1'b0;
    close_test("Branch decision");

    // 3. Lane 1 operand flipped until it is marked faulty and then clean again
    for (int n = 0; n < 8; n++) begin
      mask = $random(seed) | 32'h1;
      drive_lanes(ex_ft_pkg::ALU_ADD, $random(seed), $random(seed), $random(seed), 1'b1);
      if (n < 6) begin
        alu_req[1].operand_a = alu_req[1].operand_a ^ mask;
        exp_mis = 3'b010;
      end
      next_cycle();
    end
    close_test("Single-lane fault");

    // 4. Three different words where the vote lands on lane 0
    for (int n = 0; n < 3; n++) begin
      opa = $random(seed);
      drive_lanes(ex_ft_pkg::ALU_XOR, opa, '0, $random(seed), 1'b1);
      alu_req[1].operand_a = opa ^ 32'h1;
      alu_req[2].operand_a = opa ^ 32'h2;
      exp_mis = 3'b110;
      next_cycle();
    end
    close_test("Multi-lane fault");

    // 5. CSR read data on the ALU port and a last cycle with no source at all
    for (int n = 0; n < 6; n++) begin
      ctrl.csr_access = (n != 5);
      csr_rdata = $random(seed);
      drive_lanes(ex_ft_pkg::ALU_ADD, $random(seed), $random(seed), $random(seed), 1'b0);
      next_cycle();
    end
    ctrl.csr_access = 1'b0;
    close_test("CSR path");

    // 6. Loads, a faulting load, LSU and WB stalls, then drain
    ctrl.alu_we = 1'b0;
    ctrl.lsu_en = 1'b1;
    ctrl.regfile_we = 1'b1;
    for (int n = 0; n < 14; n++) begin
      ctrl.regfile_waddr = ex_ft_pkg::ADDR_W'($random(seed));
      lsu_rdata = $random(seed);
      lsu_err = (n == 4 || n == 5);
      lsu_ready = (n != 7);
      wb_ready = !(n >= 9 && n <= 12);
      ctrl.branch = (n == 10 || n == 11);
      if (n == 13) ctrl.lsu_en = 1'b0;
      next_cycle();
    end
    ctrl = '0;
    lsu_err = 1'b0;
    lsu_ready = 1'b1;
    wb_ready = 1'b1;
    next_cycle();
    close_test("Load write-back and stall");

    $display("%0d tests passed, %0d tests failed, %0d check errors",
      pass_cnt, fail_cnt, err_cnt);
    if (fail_cnt == 0 && err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// File: flist.f
ex_ft_pkg.sv
ex_alu.sv
ex_tmr_voter.sv
ex_tmr_alu.sv
ex_wb_reg.sv
ex_fw_mux.sv
ex_stage_ft.sv
tb_ex_stage_ft.sv

// File: Bender.yml
package:
  name: ex_stage_ft

sources:
  - ex_ft_pkg.sv
  - ex_alu.sv
  - ex_tmr_voter.sv
  - ex_tmr_alu.sv
  - ex_wb_reg.sv
  - ex_fw_mux.sv
  - ex_stage_ft.sv
  - target: test
    files:
      - tb_ex_stage_ft.sv
